/* Makefile */
# Verilator build, run and lint for the data-memory path

TOP        ?= tb_dmem
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
RUN_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the status of the pipe is the status of grep
run: build
	$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* cache/dcache.sv */
`timescale 1ns/1ns

module dcache #(
    parameter int N_SETS = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_pkg::mem_data_t             i_commit,
    output logic                             o_hit_cache,
    output logic                             o_load_cache,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_load_addr,
    input  logic                             i_load_req,
    output logic                             o_load_done,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_load_data,
    output logic                             o_mem_start,
    output logic                             o_mem_we,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_mem_adr,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_mem_wdata,
    input  logic                             i_mem_done,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_mem_rdata
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_S = TAG_W + INDEX_W - IDX_W; // unused index bits join the tag

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_CWRITE = 3'd1;
    localparam logic [2:0] S_HIT    = 3'd2;
    localparam logic [2:0] S_SETTLE = 3'd3; // stb retires during this cycle
    localparam logic [2:0] S_FILL   = 3'd4;
    localparam logic [2:0] S_LDONE  = 3'd5;

    logic [2:0]          state;
    logic [N_SETS-1:0]   valid;
    logic [TAG_S-1:0]    tag_arr  [N_SETS];
    logic [VA_WIDTH-1:0] data_arr [N_SETS];
    addr_u               ld_a;
    addr_u               cm_a;
    logic [IDX_W-1:0]    ld_idx;
    logic [IDX_W-1:0]    cm_idx;
    logic [TAG_S-1:0]    ld_tag;
    logic [TAG_S-1:0]    cm_tag;
    logic                ld_hit;
    logic                start_fill;
    logic                start_commit;
    logic                fill_wr;

    assign ld_a   = i_load_addr;
    assign cm_a   = i_commit.address;
    assign ld_idx = ld_a.f.index[IDX_W-1:0];
    assign cm_idx = cm_a.f.index[IDX_W-1:0];
    assign ld_tag = TAG_S'({ld_a.f.tag, ld_a.f.index} >> IDX_W);
    assign cm_tag = TAG_S'({cm_a.f.tag, cm_a.f.index} >> IDX_W);

    assign ld_hit = valid[ld_idx] && tag_arr[ld_idx] == ld_tag;

    // fills win over commits
    assign start_fill   = state == S_IDLE && i_load_req && !ld_hit;
    assign start_commit = state == S_IDLE && !start_fill && i_commit.enable;
    assign fill_wr      = state == S_FILL && i_mem_done;

    assign o_mem_start = start_fill || start_commit;
    assign o_mem_we    = !start_fill;
    assign o_mem_adr   = start_fill ? i_load_addr : i_commit.address;
    assign o_mem_wdata = i_commit.data;

    assign o_load_done  = (state == S_IDLE && i_load_req && ld_hit) || state == S_LDONE;
    assign o_load_data  = data_arr[ld_idx]; // line already filled in S_LDONE
    assign o_hit_cache  = state == S_HIT;
    assign o_load_cache = state == S_FILL || state == S_LDONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            valid <= '0;
        end else begin
            if (start_commit) valid[cm_idx] <= 1'b1; // allocate on write
            if (fill_wr)      valid[ld_idx] <= 1'b1;
            case (state)
                S_IDLE: begin
                    if (start_fill)        state <= S_FILL;
                    else if (start_commit) state <= S_CWRITE;
                end
                S_CWRITE: if (i_mem_done) state <= S_HIT;
                S_HIT:    state <= S_SETTLE;
                S_FILL:   if (i_mem_done) state <= S_LDONE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_commit) begin
            tag_arr[cm_idx]  <= cm_tag;
            data_arr[cm_idx] <= i_commit.data;
        end
        if (fill_wr) begin
            tag_arr[ld_idx]  <= ld_tag;
            data_arr[ld_idx] <= i_mem_rdata;
        end
    end

endmodule

/* common/cache_pkg.sv */
package cache_pkg;

    localparam int VA_WIDTH = 32;
    localparam int OFFSET_W = 2;     // word offset inside an address
    localparam int INDEX_W  = 8;     // widest index, caches use the low bits
    localparam int TAG_W    = VA_WIDTH - INDEX_W - OFFSET_W;

    // one buffered store, 65 bits
    typedef struct packed {
        logic                enable;
        logic [VA_WIDTH-1:0] address;
        logic [VA_WIDTH-1:0] data;
    } mem_data_t;

    // same address word, flat for matching or split for cache lookup
    typedef union packed {
        logic [VA_WIDTH-1:0] flat;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } f;
    } addr_u;

endpackage

/* list.f */
common/cache_pkg.sv
rtl/req_port.sv
stb/stb.sv
cache/dcache.sv
rtl/mem_master.sv
rtl/dmem_top.sv
tests/wb_mem_model.sv
tests/dmem_properties.sv
tests/tb_dmem.sv

/* rtl/dmem_top.sv */
`timescale 1ns/1ns

module dmem_top #(
    parameter int N_LINES = 4,
    parameter int N_SETS  = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_wb_adr,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_wb_dat,
    output logic                             o_wb_ack,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_wb_dat,
    output logic                             o_mem_cyc,
    output logic                             o_mem_stb,
    output logic                             o_mem_we,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_mem_adr,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_mem_dat,
    input  logic                             i_mem_ack,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_mem_dat
);
    import cache_pkg::*;

    mem_data_t           store;
    mem_data_t           commit;
    logic                full;
    logic [VA_WIDTH-1:0] load_addr;
    logic                bypass_hit;
    logic [VA_WIDTH-1:0] bypass_data;
    logic                load_req;
    logic                load_done;
    logic [VA_WIDTH-1:0] load_data;
    logic                hit_cache;
    logic                load_cache;
    logic                mem_start;
    logic                mem_we;
    logic [VA_WIDTH-1:0] mem_adr;
    logic [VA_WIDTH-1:0] mem_wdata;
    logic                mem_done;
    logic [VA_WIDTH-1:0] mem_rdata;

    req_port u_req_port (
        .clk(clk), .rst(rst),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
        .o_wb_ack(o_wb_ack), .o_wb_dat(o_wb_dat),
        .o_store(store), .i_full(full), .o_load_addr(load_addr),
        .i_bypass_hit(bypass_hit), .i_bypass_data(bypass_data),
        .o_load_req(load_req), .i_load_done(load_done), .i_load_data(load_data)
    );

    stb #(.N_LINES(N_LINES)) u_stb (
        .clk(clk), .rst(rst),
        .i_store(store), .i_load_addr(load_addr),
        .i_load_cache(load_cache), .i_hit_cache(hit_cache),
        .o_commit(commit), .o_full(full),
        .o_hit(bypass_hit), .o_read_data(bypass_data)
    );

    dcache #(.N_SETS(N_SETS)) u_dcache (
        .clk(clk), .rst(rst),
        .i_commit(commit), .o_hit_cache(hit_cache), .o_load_cache(load_cache),
        .i_load_addr(load_addr), .i_load_req(load_req),
        .o_load_done(load_done), .o_load_data(load_data),
        .o_mem_start(mem_start), .o_mem_we(mem_we), .o_mem_adr(mem_adr),
        .o_mem_wdata(mem_wdata), .i_mem_done(mem_done), .i_mem_rdata(mem_rdata)
    );

    mem_master u_mem_master (
        .clk(clk), .rst(rst),
        .i_start(mem_start), .i_we(mem_we), .i_adr(mem_adr), .i_wdata(mem_wdata),
        .o_done(mem_done), .o_rdata(mem_rdata),
        .o_mem_cyc(o_mem_cyc), .o_mem_stb(o_mem_stb), .o_mem_we(o_mem_we),
        .o_mem_adr(o_mem_adr), .o_mem_dat(o_mem_dat),
        .i_mem_ack(i_mem_ack), .i_mem_dat(i_mem_dat)
    );

endmodule

/* rtl/mem_master.sv */
`timescale 1ns/1ns

module mem_master (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_start,
    input  logic                             i_we,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_adr,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_wdata,
    output logic                             o_done,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_rdata,
    output logic                             o_mem_cyc,
    output logic                             o_mem_stb,
    output logic                             o_mem_we,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_mem_adr,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_mem_dat,
    input  logic                             i_mem_ack,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_mem_dat
);
    logic accept;
    logic finish;

    assign accept    = i_start && !o_mem_cyc; // starts while busy are dropped
    assign finish    = o_mem_cyc && i_mem_ack;
    assign o_mem_stb = o_mem_cyc;             // single beat, stb follows cyc

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_mem_cyc <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            o_done <= finish;
            if (accept)      o_mem_cyc <= 1'b1;
            else if (finish) o_mem_cyc <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_mem_we  <= i_we;
            o_mem_adr <= i_adr;
            o_mem_dat <= i_wdata;
        end
        if (finish && !o_mem_we) o_rdata <= i_mem_dat;
    end

endmodule

/* rtl/req_port.sv */
`timescale 1ns/1ns

module req_port (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_wb_adr,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_wb_dat,
    output logic                             o_wb_ack,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_wb_dat,
    output cache_pkg::mem_data_t             o_store,
    input  logic                             i_full,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_load_addr,
    input  logic                             i_bypass_hit,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_bypass_data,
    output logic                             o_load_req,
    input  logic                             i_load_done,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_load_data
);
    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_STORE  = 2'd1;   // waiting for buffer room
    localparam logic [1:0] S_LOOKUP = 2'd2;
    localparam logic [1:0] S_LWAIT  = 2'd3;   // waiting on the cache

    logic [1:0] state;
    logic       wr_req;
    logic       rd_req;

    // processor holds the request through the ack cycle, so mask it there
    assign wr_req = i_wb_cyc && i_wb_stb && i_wb_we && !o_wb_ack;
    assign rd_req = i_wb_cyc && i_wb_stb && !i_wb_we && !o_wb_ack;

    assign o_store.enable  = wr_req && (state == S_IDLE || state == S_STORE);
    assign o_store.address = i_wb_adr;
    assign o_store.data    = i_wb_dat;

    assign o_load_addr = i_wb_adr;
    assign o_load_req  = (state == S_LOOKUP && !i_bypass_hit) || state == S_LWAIT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (wr_req) begin
                        if (!i_full) o_wb_ack <= 1'b1; // pushed this cycle
                        else         state    <= S_STORE;
                    end else if (rd_req) begin
                        state <= S_LOOKUP;
                    end
                end
                S_STORE: begin
                    if (!i_full) begin
                        o_wb_ack <= 1'b1;
                        state    <= S_IDLE;
                    end
                end
                S_LOOKUP: begin
                    if (i_bypass_hit || i_load_done) begin
                        o_wb_ack <= 1'b1;
                        state    <= S_IDLE;
                    end else begin
                        state <= S_LWAIT;
                    end
                end
                default: begin
                    if (i_load_done) begin
                        o_wb_ack <= 1'b1;
                        state    <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_LOOKUP && i_bypass_hit) o_wb_dat <= i_bypass_data;
        else if (o_load_req && i_load_done)    o_wb_dat <= i_load_data;
    end

endmodule

/* stb/stb.sv */
`timescale 1ns/1ns

module stb #(
    parameter int N_LINES = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_pkg::mem_data_t             i_store,
    input  logic [cache_pkg::VA_WIDTH-1:0]   i_load_addr,
    input  logic                             i_load_cache,
    input  logic                             i_hit_cache,
    output cache_pkg::mem_data_t             o_commit,
    output logic                             o_full,
    output logic                             o_hit,
    output logic [cache_pkg::VA_WIDTH-1:0]   o_read_data
);
    import cache_pkg::*;

    // N_LINES must be a power of two so the pointers wrap on their own
    localparam int LINE_SEL = $clog2(N_LINES);

    logic [N_LINES-1:0]   valid;
    logic [VA_WIDTH-1:0]  addr_q [N_LINES];
    logic [VA_WIDTH-1:0]  data_q [N_LINES];
    logic [LINE_SEL-1:0]  oldest_line;
    logic [LINE_SEL-1:0]  newest_line;
    logic                 hit_cache_q;
    logic                 load_cache_q;
    logic                 push;
    logic                 retire;
    addr_u                load_a;

    assign load_a = i_load_addr;

    assign o_full = i_store.enable && valid[newest_line]; // newest slot still busy
    assign push   = i_store.enable && !valid[newest_line];
    assign retire = hit_cache_q && !load_cache_q && valid[oldest_line];

    assign o_commit.enable  = valid[oldest_line];
    assign o_commit.address = addr_q[oldest_line];
    assign o_commit.data    = data_q[oldest_line];

    // walk oldest to newest, last match is the youngest store
    always_comb begin : load_bypass
        logic [LINE_SEL-1:0] idx;
        o_hit       = 1'b0;
        o_read_data = '0;
        for (int k = 0; k < N_LINES; k++) begin
            idx = oldest_line + LINE_SEL'(k);
            if (valid[idx] && addr_q[idx] == load_a.flat) begin
                o_hit       = 1'b1;
                o_read_data = data_q[idx];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid        <= '0;
            oldest_line  <= '0;
            newest_line  <= '0;
            hit_cache_q  <= 1'b0;
            load_cache_q <= 1'b0;
        end else begin
            hit_cache_q  <= i_hit_cache;
            load_cache_q <= i_load_cache;
            if (retire) begin // commit finished last cycle
                valid[oldest_line] <= 1'b0;
                oldest_line        <= oldest_line + 1'b1;
            end
            if (push) begin
                valid[newest_line] <= 1'b1;
                newest_line        <= newest_line + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[newest_line] <= i_store.address;
            data_q[newest_line] <= i_store.data;
        end
    end

endmodule

/* tests/dmem_properties.sv */
`timescale 1ns/1ns

module dmem_properties (
    input logic clk,
    input logic rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_mem_cyc,
    input logic i_mem_stb,
    input logic i_mem_ack,
    input logic i_full
);
    int unsigned fails = 0; // read by the testbench at the end

    wb_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        i_wb_ack |-> i_wb_cyc && i_wb_stb)
        else begin
            $error("processor ack outside cyc and stb");
            fails++;
        end

    mem_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        i_mem_ack |-> i_mem_cyc && i_mem_stb)
        else begin
            $error("memory ack outside cyc and stb");
            fails++;
        end

    mem_stb_held: assert property (@(posedge clk) disable iff (rst)
        i_mem_stb && !i_mem_ack |=> i_mem_stb)
        else begin
            $error("memory stb dropped before ack");
            fails++;
        end

    // a full buffer must hold the store back
    no_ack_when_full: assert property (@(posedge clk) disable iff (rst)
        i_full |=> !i_wb_ack)
        else begin
            $error("store acknowledged while the buffer was full");
            fails++;
        end

endmodule

bind dmem_top dmem_properties u_props (
    .clk(clk),
    .rst(rst),
    .i_wb_cyc(i_wb_cyc),
    .i_wb_stb(i_wb_stb),
    .i_wb_ack(o_wb_ack),
    .i_mem_cyc(o_mem_cyc),
    .i_mem_stb(o_mem_stb),
    .i_mem_ack(i_mem_ack),
    .i_full(full)
);

/* tests/dmem_testdata.txt */
// op addr word; op 0 preloads memory, 1 stores, 2 loads and expects word
// op 3 ends the test numbered by addr, op f ends the list
0 00000100 11110100
0 00000200 22220200
0 00000044 44440044
// store then load from the store buffer
1 00000010 a5a50010
2 00000010 a5a50010
3 00000002 00000000
// miss fill, repeat hit, then a conflicting set
2 00000100 11110100
2 00000100 11110100
2 00000200 22220200
3 00000003 00000000
// burst deeper than the buffer with repeated addresses
1 00000020 00000001
1 00000024 00000002
1 00000020 00000003
1 00000028 00000004
1 00000024 00000005
1 0000002c 00000006
1 00000044 00000007
2 00000020 00000003
2 00000024 00000005
2 00000044 00000007
2 00000010 a5a50010
3 00000004 00000000
f 00000000 00000000

/* tests/tb_dmem.sv */
`timescale 1ns/1ns

module tb_dmem;
    import cache_pkg::*;

    localparam int N_LINES = 4;
    localparam int N_SETS  = 16;
    localparam int MAX_OPS = 64;

    logic                clk = 1'b0;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [VA_WIDTH-1:0] wb_adr;
    logic [VA_WIDTH-1:0] wb_dat;
    logic                wb_ack;
    logic [VA_WIDTH-1:0] wb_rdat;
    logic                mem_cyc;
    logic                mem_stb;
    logic                mem_we;
    logic [VA_WIDTH-1:0] mem_adr;
    logic [VA_WIDTH-1:0] mem_wdat;
    logic                mem_ack;
    logic [VA_WIDTH-1:0] mem_rdat;
    logic [1:0]          mem_wait = 2'd0;
    logic                init_we;
    logic [31:0]         init_adr;
    logic [31:0]         init_dat;
    logic [31:0]         peek_adr;
    logic [31:0]         peek_dat;

    logic [31:0] td [3*MAX_OPS];
    bit   [31:0] ref_mem [bit [31:0]]; // last value written per address
    logic [31:0] stored_q [$];
    logic [31:0] lfsr = 32'h5a88c73c;
    int          cycles = 0;
    int          limit;
    int          n_ops;
    int          err_count = 0;
    int          test_errs = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    dmem_top #(.N_LINES(N_LINES), .N_SETS(N_SETS)) i_dmem_top (
        .clk(clk), .rst(rst),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_adr(wb_adr), .i_wb_dat(wb_dat),
        .o_wb_ack(wb_ack), .o_wb_dat(wb_rdat),
        .o_mem_cyc(mem_cyc), .o_mem_stb(mem_stb), .o_mem_we(mem_we),
        .o_mem_adr(mem_adr), .o_mem_dat(mem_wdat),
        .i_mem_ack(mem_ack), .i_mem_dat(mem_rdat)
    );

    wb_mem_model u_mem (
        .clk(clk), .rst(rst),
        .i_cyc(mem_cyc), .i_stb(mem_stb), .i_we(mem_we),
        .i_adr(mem_adr), .i_dat(mem_wdat),
        .o_ack(mem_ack), .o_dat(mem_rdat), .i_wait(mem_wait),
        .i_init_we(init_we), .i_init_adr(init_adr), .i_init_dat(init_dat),
        .i_peek_adr(peek_adr), .o_peek_dat(peek_dat)
    );

    always #5 clk = ~clk;

    // galois lfsr, stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return v;
    endfunction

    always @(posedge clk) begin
        #2;
        mem_wait = 2'(take_bits(2)); // memory wait states for the next beat
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset idle";
            2:       return "store bypass";
            3:       return "miss fill then hit";
            4:       return "burst past buffer depth";
            5:       return "write-through drain";
            default: return "unnamed";
        endcase
    endfunction

    task automatic note_error();
        test_errs++;
        err_count++;
    endtask

    task automatic end_test(input int n);
        if (test_errs == 0) begin
            n_pass++;
            $display("test %0d (%s) passed", n, test_name(n));
        end else begin
            n_fail++;
            $display("test %0d (%s) failed with %0d errors", n, test_name(n), test_errs);
        end
        test_errs = 0;
    endtask

    // nothing may move on either bus before the first request
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        if (wb_ack !== 1'b0) begin
            $display("MISMATCH o_wb_ack: got %h expected 0", wb_ack);
            note_error();
        end
        if (mem_cyc !== 1'b0) begin
            $display("MISMATCH o_mem_cyc: got %h expected 0", mem_cyc);
            note_error();
        end
    endtask

    task automatic preload(input logic [31:0] adr, input logic [31:0] dat);
        init_we  = 1'b1;
        init_adr = adr;
        init_dat = dat;
        idle_cycle();
        init_we     = 1'b0;
        ref_mem[adr] = dat;
    endtask

    task automatic bus_op(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                          output logic [31:0] rdata, output int ack_cycles);
        logic [31:0] gap;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = dat;
        ack_cycles = 0;
        do begin
            @(posedge clk);
            #1;
            ack_cycles++;
        end while (!wb_ack);
        rdata = wb_rdat;
        @(posedge clk); // request stays up through the ack cycle
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        gap = take_bits(2);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_load(input logic [31:0] adr, input logic [31:0] exp,
                              input logic after_store);
        logic [31:0] rdata;
        int          lat;
        if (!ref_mem.exists(adr)) begin
            $display("load from %h has no stored or preloaded value to compare with", adr);
            note_error();
        end else if (ref_mem[adr] != exp) begin
            $display("test data expects %h at %h but the last write there was %h",
                     exp, adr, ref_mem[adr]);
            note_error();
        end
        bus_op(1'b0, adr, '0, rdata, lat);
        if (rdata != exp) begin
            $display("MISMATCH o_wb_dat at %h: got %h expected %h", adr, rdata, exp);
            note_error();
        end
        // its own store is still buffered, so only a bypass answers this fast
        if (after_store && lat != 2) begin
            $display("load from %h right after a store to it took %0d cycles instead of 2",
                     adr, lat);
            note_error();
        end
    endtask

    initial begin
        logic [31:0] op;
        logic [31:0] adr;
        logic [31:0] val;
        logic [31:0] rdata;
        logic [31:0] prev_op;
        logic [31:0] prev_adr;
        int          lat;
        int          i;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat   = '0;
        init_we  = 1'b0;
        init_adr = '0;
        init_dat = '0;
        peek_adr = '0;
        prev_op  = '0;
        prev_adr = '0;
        $readmemh("tests/dmem_testdata.txt", td);
        n_ops = 0;
        while (n_ops < MAX_OPS && td[3*n_ops] != 32'hf) n_ops++;
        limit = 200 * n_ops + 500;

        repeat (10) idle_cycle();
        rst = 1'b0;
        i = 0;
        while (i < n_ops && td[3*i] == 32'h0) begin
            preload(td[3*i+1], td[3*i+2]);
            i++;
        end
        idle_cycle();
        end_test(1);

        while (i < n_ops) begin
            op  = td[3*i];
            adr = td[3*i+1];
            val = td[3*i+2];
            if (op == 32'h1) begin
                bus_op(1'b1, adr, val, rdata, lat);
                ref_mem[adr] = val;
                stored_q.push_back(adr);
            end else if (op == 32'h2) begin
                check_load(adr, val, prev_op == 32'h1 && prev_adr == adr);
            end else if (op == 32'h3) begin
                end_test(int'(adr));
            end else begin
                $display("unknown operation %h at entry %0d of the test data", op, i);
                note_error();
            end
            prev_op  = op;
            prev_adr = adr;
            i++;
        end

        // drain the store buffer, then compare memory with the reference
        while (i_dmem_top.u_stb.valid != '0 || mem_cyc) begin
            @(posedge clk);
            #1;
        end
        foreach (stored_q[k]) begin
            peek_adr = stored_q[k];
            #1;
            if (peek_dat != ref_mem[stored_q[k]]) begin
                $display("MISMATCH o_peek_dat at %h: got %h expected %h",
                         stored_q[k], peek_dat, ref_mem[stored_q[k]]);
                note_error();
            end
        end
        if (i_dmem_top.u_props.fails != 0) begin
            $display("%0d concurrent assertion failures", i_dmem_top.u_props.fails);
            note_error();
        end
        end_test(5);

        $display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tests/wb_mem_model.sv */
`timescale 1ns/1ns

module wb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    output logic        o_ack,
    output logic [31:0] o_dat,
    input  logic [1:0]  i_wait,
    input  logic        i_init_we,
    input  logic [31:0] i_init_adr,
    input  logic [31:0] i_init_dat,
    input  logic [31:0] i_peek_adr,
    output logic [31:0] o_peek_dat
);
    logic [31:0]  mem [256];
    logic [255:0] written;
    logic         busy;
    logic [1:0]   wait_cnt;
    logic [7:0]   idx;
    logic         beat_done;

    // words never written read back as a pattern of the full address
    function automatic logic [31:0] fill_word(input logic [31:0] adr);
        return adr ^ {adr[15:0], adr[31:16]} ^ 32'h6b1d2e47;
    endfunction

    assign idx       = i_adr[9:2];
    assign beat_done = i_cyc && i_stb && !o_ack && busy && wait_cnt == 2'd0;

    assign o_peek_dat = written[i_peek_adr[9:2]] ? mem[i_peek_adr[9:2]]
                                                 : fill_word(i_peek_adr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_ack    <= 1'b0;
            o_dat    <= '0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            written  <= '0;
        end else begin
            o_ack <= 1'b0;
            if (beat_done) o_dat <= written[idx] ? mem[idx] : fill_word(i_adr);
            if (i_init_we) written[i_init_adr[9:2]] <= 1'b1;
            if (i_cyc && i_stb && !o_ack) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= i_wait; // wait states for this beat
                end else if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    o_ack <= 1'b1;
                    busy  <= 1'b0;
                    if (i_we) written[idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_init_we) mem[i_init_adr[9:2]] <= i_init_dat;
        if (beat_done && i_we) mem[idx] <= i_dat;
    end

endmodule
